// ==== rtl/process_audio_pkg.sv ====
package process_audio_pkg;

    // pcm sample as delivered by the microphone
    typedef logic signed [15:0] audio_sample_t;

    // q1.15 filter coefficient
    typedef logic signed [15:0] coef_t;

    // tap partial sum, full product plus headroom for the chain
    typedef logic signed [35:0] acc_t;

    typedef struct packed {
        logic          valid;
        audio_sample_t data;
    } sample_stream_t;

    typedef struct packed {
        logic valid;
        acc_t sum;
    } acc_stream_t;

    typedef enum logic {
        CALIBRATING,
        RUNNING
    } calib_state_t;

    localparam int NUM_TAPS = 8;
    localparam int COEF_FRAC = 15;

    // symmetric low-pass, cutoff near 10 kHz at 48 kHz, taps sum to 32768
    localparam coef_t FIR_COEFS [NUM_TAPS] = '{
        -16'sd328, 16'sd1066, 16'sd5466, 16'sd10180,
        16'sd10180, 16'sd5466, 16'sd1066, -16'sd328
    };

endpackage

// ==== rtl/dc_offset_remover.sv ====
`timescale 1ns/1ps

module dc_offset_remover #(
    parameter int CAL_LOG2 = 4
) (
    input  logic                              audio_clk,
    input  logic                              rst_in,
    input  logic                              sample_valid,
    input  process_audio_pkg::audio_sample_t  sample_in,
    output process_audio_pkg::audio_sample_t  raw_audio,
    output logic                              calibrated,
    output process_audio_pkg::sample_stream_t dc_stream
);

    // running sum over the calibration window
    logic signed [15+CAL_LOG2:0]      cal_sum;
    logic signed [15+CAL_LOG2:0]      cal_sum_next;
    logic [CAL_LOG2-1:0]              cal_count;
    process_audio_pkg::audio_sample_t offset;
    process_audio_pkg::calib_state_t  state;

    assign cal_sum_next = cal_sum + sample_in;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state      <= process_audio_pkg::CALIBRATING;
            calibrated <= 1'b0;
            cal_count  <= '0;
            cal_sum    <= '0;
            offset     <= '0;
        end else begin
            case (state)
                process_audio_pkg::CALIBRATING: begin
                    if (sample_valid) begin
                        cal_sum   <= cal_sum_next;
                        cal_count <= cal_count + 1'b1;
                        // last sample of the window closes calibration
                        if (&cal_count) begin
                            // arithmetic shift floors the mean
                            offset <= process_audio_pkg::audio_sample_t'(
                                cal_sum_next >>> CAL_LOG2);
                            state      <= process_audio_pkg::RUNNING;
                            calibrated <= 1'b1;
                        end
                    end
                end
                process_audio_pkg::RUNNING: begin
                    // offset stays latched until the next reset
                    state <= process_audio_pkg::RUNNING;
                end
                default: begin
                    state <= process_audio_pkg::CALIBRATING;
                end
            endcase
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            dc_stream.valid <= 1'b0;
        end else begin
            dc_stream.valid <= sample_valid;
        end

        if (sample_valid) begin
            raw_audio <= sample_in;
            // offset is still zero for every sample of the window
            dc_stream.data <= sample_in - offset;
        end
    end

endmodule

// ==== rtl/fir_tap.sv ====
`timescale 1ns/1ps

module fir_tap #(
    parameter process_audio_pkg::coef_t COEF = '0
) (
    input  logic                              audio_clk,
    input  logic                              rst_in,
    input  process_audio_pkg::sample_stream_t sample_in,
    input  process_audio_pkg::acc_t           sum_in,
    output process_audio_pkg::acc_stream_t    sum_out
);

    process_audio_pkg::acc_t product;

    // both operands sign extended before the multiply
    assign product = process_audio_pkg::acc_t'(sample_in.data)
                   * process_audio_pkg::acc_t'(COEF);

    // transposed form register, holds this tap's share of a later output
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            sum_out <= '0;
        end else begin
            sum_out.valid <= sample_in.valid;
            if (sample_in.valid) begin
                sum_out.sum <= product + sum_in;
            end
        end
    end

endmodule

// ==== rtl/decimator.sv ====
`timescale 1ns/1ps

module decimator (
    input  logic                             audio_clk,
    input  logic                             rst_in,
    input  process_audio_pkg::acc_stream_t   fir_stream,
    output process_audio_pkg::audio_sample_t processed_audio,
    output logic                             processed_valid
);

    localparam process_audio_pkg::acc_t HALF_LSB =
        process_audio_pkg::acc_t'(1) <<< (process_audio_pkg::COEF_FRAC - 1);
    localparam process_audio_pkg::acc_t SAT_MAX = 36'sd32767;
    localparam process_audio_pkg::acc_t SAT_MIN = -36'sd32768;

    logic                             phase;
    logic                             keep;
    process_audio_pkg::acc_t          rounded;
    process_audio_pkg::acc_t          scaled;
    process_audio_pkg::audio_sample_t saturated;

    assign keep    = fir_stream.valid && !phase;
    assign rounded = fir_stream.sum + HALF_LSB;
    assign scaled  = rounded >>> process_audio_pkg::COEF_FRAC;

    always_comb begin
        if (scaled > SAT_MAX) begin
            saturated = 16'sh7fff;
        end else if (scaled < SAT_MIN) begin
            saturated = 16'sh8000;
        end else begin
            saturated = scaled[15:0];
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            phase           <= 1'b0;
            processed_valid <= 1'b0;
        end else begin
            processed_valid <= keep;
            if (fir_stream.valid) begin
                phase <= ~phase;
            end
        end

        if (keep) begin
            processed_audio <= saturated;
        end
    end

endmodule

// ==== rtl/process_audio.sv ====
`timescale 1ns/1ps

module process_audio #(
    parameter int CAL_LOG2 = 4
) (
    input  logic                             audio_clk,
    input  logic                             rst_in,
    input  logic                             sample_valid,
    input  process_audio_pkg::audio_sample_t sample_in,
    output process_audio_pkg::audio_sample_t raw_audio,
    output logic                             calibrated,
    output process_audio_pkg::audio_sample_t processed_audio,
    output logic                             processed_valid
);

    process_audio_pkg::sample_stream_t dc_stream;
    process_audio_pkg::acc_stream_t    tap_out [process_audio_pkg::NUM_TAPS];

    dc_offset_remover #(
        .CAL_LOG2(CAL_LOG2)
    ) u_dc_offset_remover (
        .audio_clk   (audio_clk),
        .rst_in      (rst_in),
        .sample_valid(sample_valid),
        .sample_in   (sample_in),
        .raw_audio   (raw_audio),
        .calibrated  (calibrated),
        .dc_stream   (dc_stream)
    );

    // every tap sees the same sample, partial sums move toward tap 0
    for (genvar k = 0; k < process_audio_pkg::NUM_TAPS; k++) begin : g_tap
        process_audio_pkg::acc_t sum_in;

        if (k == process_audio_pkg::NUM_TAPS - 1) begin : g_last
            assign sum_in = '0;
        end else begin : g_chain
            assign sum_in = tap_out[k + 1].sum;
        end

        fir_tap #(
            .COEF(process_audio_pkg::FIR_COEFS[k])
        ) u_fir_tap (
            .audio_clk(audio_clk),
            .rst_in   (rst_in),
            .sample_in(dc_stream),
            .sum_in   (sum_in),
            .sum_out  (tap_out[k])
        );
    end

    decimator u_decimator (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .fir_stream     (tap_out[0]),
        .processed_audio(processed_audio),
        .processed_valid(processed_valid)
    );

endmodule

// ==== tb/process_audio_properties.sv ====
`timescale 1ns/1ps

module process_audio_properties (
    input logic                            audio_clk,
    input logic                            rst_in,
    input logic                            processed_valid,
    input logic                            calibrated,
    input process_audio_pkg::calib_state_t state
);

    // decimation leaves at most one result per pair of samples
    single_strobe: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        processed_valid |=> !processed_valid
    ) else $error("processed_valid high on two consecutive cycles");

    calibrated_sticky: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        calibrated |=> calibrated
    ) else $error("calibrated fell outside reset");

    state_matches_flag: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        (state == process_audio_pkg::RUNNING) == calibrated
    ) else $error("calibration state and calibrated flag disagree");

    // covers every reset cycle and the first cycle after it
    quiet_after_reset: assert property (
        @(posedge audio_clk)
        rst_in |=> !processed_valid
    ) else $error("processed_valid high during or just after reset");

endmodule

bind process_audio process_audio_properties u_properties (
    .audio_clk      (audio_clk),
    .rst_in         (rst_in),
    .processed_valid(processed_valid),
    .calibrated     (calibrated),
    .state          (u_dc_offset_remover.state)
);

// ==== tb/tb_process_audio.sv ====
`timescale 1ns/1ps

module tb_process_audio;

    localparam int CLK_PERIOD = 8;
    localparam int STRIDE = 4;
    localparam int CAL_SAMPLES = 16;
    localparam int TOTAL_SAMPLES = 308;
    localparam int CYCLE_LIMIT = TOTAL_SAMPLES * STRIDE + 100;
    localparam logic signed [15:0] DC_LEVEL = -16'sd1203;

    // q1.15 low-pass taps
    localparam int COEFS [8] = '{-328, 1066, 5466, 10180, 10180, 5466, 1066, -328};

    logic                             audio_clk;
    logic                             rst_in;
    logic                             sample_valid;
    process_audio_pkg::audio_sample_t sample_in;
    process_audio_pkg::audio_sample_t raw_audio;
    logic                             calibrated;
    process_audio_pkg::audio_sample_t processed_audio;
    logic                             processed_valid;

    // reference model state
    logic signed [15:0] history [8];
    logic signed [15:0] model_offset;
    logic signed [15:0] expected_q [$];
    logic signed [15:0] expected_audio;
    int                 model_count;
    int                 cal_acc;

    integer seed;
    int     error_count;
    int     test_count;
    int     failed_tests;
    int     test_error_base;
    int     strobe_count;
    int     sat_high_count;
    int     sat_low_count;
    int     cycle_count;
    int     strobe_base;
    int     sat_high_base;
    int     sat_low_base;

    process_audio #(
        .CAL_LOG2(4)
    ) dut (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .sample_valid   (sample_valid),
        .sample_in      (sample_in),
        .raw_audio      (raw_audio),
        .calibrated     (calibrated),
        .processed_audio(processed_audio),
        .processed_valid(processed_valid)
    );

    initial audio_clk = 1'b0;
    always #(CLK_PERIOD / 2) audio_clk = ~audio_clk;

    always @(posedge audio_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s at %0t ns: got 0x%08h, expected 0x%08h",
                     name, $time, actual, expected);
            error_count++;
        end
    endtask

    // filter sum over the corrected history before rounding, scaling and clamping
    function automatic logic signed [15:0] fir_reference();
        longint acc;
        longint scaled;
        acc = 0;
        for (int k = 0; k < 8; k++) begin
            acc += longint'(COEFS[k]) * longint'(history[k]);
        end
        scaled = (acc + 64'sd16384) >>> 15;
        if (scaled > 32767) begin
            return 16'sh7fff;
        end
        if (scaled < -32768) begin
            return 16'sh8000;
        end
        return scaled[15:0];
    endfunction

    task automatic model_push(input logic signed [15:0] value);
        logic signed [15:0] corrected;
        corrected = value - model_offset;
        if (model_count < CAL_SAMPLES) begin
            cal_acc += value;
        end
        model_count++;
        // offset latched on the last calibration sample applies from the next one
        if (model_count == CAL_SAMPLES) begin
            model_offset = 16'(cal_acc >>> $clog2(CAL_SAMPLES));
        end
        for (int k = 7; k > 0; k--) begin
            history[k] = history[k - 1];
        end
        history[0] = corrected;
        // odd-numbered samples survive decimation
        if (model_count % 2 == 1) begin
            expected_q.push_back(fir_reference());
        end
    endtask

    task automatic send_sample(input logic signed [15:0] value);
        @(posedge audio_clk);
        #1;
        sample_valid = 1'b1;
        sample_in    = value;
        model_push(value);
        @(posedge audio_clk);
        #1;
        sample_valid = 1'b0;
        @(posedge audio_clk);
        #1;
        check_value("raw_audio", raw_audio, value);
        @(posedge audio_clk);
    endtask

    task automatic drain_outputs();
        repeat (4) @(posedge audio_clk);
        if (expected_q.size() != 0) begin
            $display("%0d expected outputs never appeared at processed_audio",
                     expected_q.size());
            error_count++;
            expected_q.delete();
        end
    endtask

    task automatic start_test();
        test_error_base = error_count;
        strobe_base     = strobe_count;
        sat_high_base   = sat_high_count;
        sat_low_base    = sat_low_count;
    endtask

    task automatic report_test(input string name);
        int errors;
        errors = error_count - test_error_base;
        test_count++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("test %-12s %s (%0d errors)", name, errors == 0 ? "ok" : "failed", errors);
    endtask

    always @(negedge audio_clk) begin
        if (!rst_in && processed_valid) begin
            strobe_count++;
            if (processed_audio == 16'sh7fff) begin
                sat_high_count++;
            end
            if (processed_audio == 16'sh8000) begin
                sat_low_count++;
            end
            if (expected_q.size() == 0) begin
                $display("output strobe at %0t ns with no expected value pending", $time);
                error_count++;
            end else begin
                expected_audio = expected_q.pop_front();
                check_value("processed_audio", processed_audio, expected_audio);
            end
        end
    end

    initial begin
        logic signed [15:0] value;
        seed         = 32'h434fe470;
        rst_in       = 1'b1;
        sample_valid = 1'b0;
        sample_in    = '0;
        model_offset = '0;
        model_count  = 0;
        cal_acc      = 0;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_count  = 0;
        strobe_count = 0;
        sat_high_count = 0;
        sat_low_count  = 0;
        for (int k = 0; k < 8; k++) begin
            history[k] = '0;
        end

        start_test();
        repeat (3) begin
            @(posedge audio_clk);
            #1;
            check_value("processed_valid", processed_valid, 0);
            check_value("calibrated", calibrated, 0);
        end
        rst_in = 1'b0;
        @(posedge audio_clk);
        #1;
        check_value("processed_valid", processed_valid, 0);
        check_value("calibrated", calibrated, 0);
        drain_outputs();
        report_test("reset");

        start_test();
        for (int i = 0; i < CAL_SAMPLES; i++) begin
            check_value("calibrated", calibrated, 0);
            send_sample(DC_LEVEL);
        end
        check_value("calibrated", calibrated, 1);
        repeat (12) send_sample(DC_LEVEL);
        check_value("processed_audio", processed_audio, 0);
        drain_outputs();
        report_test("calibration");

        // single half-scale impulse among baseline samples
        start_test();
        repeat (2) send_sample(DC_LEVEL);
        send_sample(DC_LEVEL + 16'sd16384);
        repeat (9) send_sample(DC_LEVEL);
        drain_outputs();
        report_test("impulse");

        start_test();
        for (int i = 0; i < 8; i++) begin
            send_sample(16'(i * 4099 - 16000));
        end
        drain_outputs();
        report_test("raw_path");

        start_test();
        for (int i = 0; i < 200; i++) begin
            value = $random(seed);
            send_sample(value);
        end
        drain_outputs();
        check_value("processed_valid count", strobe_count - strobe_base, 100);
        report_test("random");

        // corrected full-scale runs overshoot through the negative end taps
        start_test();
        repeat (3) begin
            repeat (10) send_sample(16'sh7fff + model_offset);
            repeat (10) send_sample(16'sh8000 + model_offset);
        end
        drain_outputs();
        if (sat_high_count == sat_high_base) begin
            $display("saturation: processed_audio never clamped at 32767");
            error_count++;
        end
        if (sat_low_count == sat_low_base) begin
            $display("saturation: processed_audio never clamped at -32768");
            error_count++;
        end
        report_test("saturation");

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d output strobes",
                 test_count, failed_tests, error_count, strobe_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== process_audio.f ====
rtl/process_audio_pkg.sv
rtl/dc_offset_remover.sv
rtl/fir_tap.sv
rtl/decimator.sv
rtl/process_audio.sv
tb/process_audio_properties.sv
tb/tb_process_audio.sv

// ==== Makefile ====
# Verilator flow for the microphone front end

TOP   := tb_process_audio
FLIST := process_audio.f

.PHONY: all lint sim clean

all: sim

# style and width findings are printed but do not stop the flow
lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) \
		-f $(FLIST)

# the run passes only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
